// ==== design/pwm_consts.svh ====
// PWM host constants
`ifndef PWM_CONSTS_SVH
`define PWM_CONSTS_SVH

// Counter and duty resolution
`define PWM_WIDTH 12

// Fixed channel count, tied to the 8-bit pattern byte
`define PWM_CHANNELS 3

// Pattern register
`define LFSR_WIDTH 26
`define PATTERN_SEED 26'h123ABCD // Any nonzero value

// Default trigger sequence
`define TRIGGER_FIRST 8'hAA
`define TRIGGER_SECOND 8'h55

`endif

// ==== design/pwm_pkg.sv ====
// PWM host types
`include "pwm_consts.svh"

package pwm_pkg;

    // Count, period and duty share one width
    typedef logic [`PWM_WIDTH-1:0] duty_t;

    typedef logic [`LFSR_WIDTH-1:0] pattern_t;

    // Byte window offered to the detector
    typedef logic [7:0] pattern_byte_t;

    typedef logic [$clog2(`PWM_CHANNELS)-1:0] chan_sel_t; // Channel index
    typedef logic [`PWM_CHANNELS-1:0] chan_bits_t;        // One bit per channel

    // Timebase FSM
    typedef enum logic [1:0] {
        TB_IDLE  = 2'd0,
        TB_COUNT = 2'd1,
        TB_WRAP  = 2'd2
    } timebase_state_t;

endpackage

// ==== design/pwm_timebase_if.sv ====
// Timebase to channel bank link

interface pwm_timebase_if
    import pwm_pkg::*;
();

    duty_t count;       // Current timebase count
    logic running;      // Enabled and not being cleared
    logic period_pulse; // Same pulse as period_complete
    logic clear;        // Force-clear from the detector

    // Producer side
    modport timebase (
        output count,
        output running,
        output period_pulse,
        input  clear
    );

    // Consumer side
    modport bank (
        input count,
        input running,
        input period_pulse,
        input clear
    );

endinterface

// ==== design/pwm_timebase.sv ====
// PWM period counter
`include "pwm_consts.svh"

module pwm_timebase
    import pwm_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  duty_t period_value,
    output logic period_complete,
    pwm_timebase_if.timebase tb
);

    timebase_state_t state;
    duty_t count;
    logic period_q;

    // Clear wins over enable
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= TB_IDLE;
            count <= '0;
            period_q <= 1'b0;
        end else if (tb.clear || !enable) begin
            state <= TB_IDLE;
            count <= '0;
            period_q <= 1'b0;
        end else begin
            period_q <= 1'b0; // Pulse lasts a single cycle
            case (state)
                TB_IDLE: begin
                    count <= '0;
                    state <= TB_COUNT;
                end
                TB_COUNT: begin
                    if (count >= period_value) begin
                        count <= '0;
                        period_q <= 1'b1;
                        state <= TB_WRAP;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                TB_WRAP: begin
                    state <= TB_COUNT; // Count holds at zero here
                end
                default: begin
                    state <= TB_IDLE;
                end
            endcase
        end
    end

    assign tb.count = count;
    assign tb.running = enable && !tb.clear;
    assign tb.period_pulse = period_q;
    assign period_complete = period_q;

    // WRAP always separates two pulses
    period_no_repeat: assert property (
        @(posedge clk) disable iff (rst)
        period_complete |=> !period_complete
    ) else $error("period_complete high on consecutive cycles");

    // Only checked once the period setting has settled
    count_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (tb.running && $stable(period_value)) |-> (count <= period_value)
    ) else $error("timebase count above period_value");

endmodule

// ==== design/pattern_source.sv ====
// LFSR pattern source
`include "pwm_consts.svh"

module pattern_source
    import pwm_pkg::*;
#(
    parameter pattern_t seed = `PATTERN_SEED
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic period_pulse,
    output pattern_byte_t pattern_byte
);

    pattern_t lfsr;
    chan_sel_t chan_sel;
    logic feedback;

    // Taps 25, 21, 15, 4
    assign feedback = lfsr[25] ^ lfsr[21] ^ lfsr[15] ^ lfsr[4];

    // Frozen while disabled, untouched by the force-clear
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= seed;
            chan_sel <= '0;
        end else if (enable) begin
            lfsr <= {lfsr[`LFSR_WIDTH-2:0], feedback};
            if (period_pulse) begin
                if (chan_sel == chan_sel_t'(`PWM_CHANNELS - 1))
                    chan_sel <= '0;
                else
                    chan_sel <= chan_sel + 1'b1;
            end
        end
    end

    // Byte window follows the channel index
    always_comb begin
        case (chan_sel)
            2'd0: pattern_byte = lfsr[7:0];
            2'd1: pattern_byte = lfsr[15:8];
            2'd2: pattern_byte = lfsr[23:16];
            default: pattern_byte = lfsr[7:0]; // Index never reaches 3
        endcase
    end

    // A zero state would lock the stream
    lfsr_nonzero: assert property (
        @(posedge clk) disable iff (rst)
        lfsr != '0
    ) else $error("pattern LFSR reached zero");

endmodule

// ==== design/trigger_detector.sv ====
// Two-byte trigger detector

module trigger_detector
    import pwm_pkg::*;
#(
    parameter pattern_byte_t trigger_first = 8'hAA,
    parameter pattern_byte_t trigger_second = 8'h55
) (
    input  logic clk,
    input  logic rst,
    input  pattern_byte_t data_in,
    output logic force_clear
);

    logic armed; // First byte seen last cycle
    logic hit;

    assign hit = armed && (data_in == trigger_second);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            armed <= 1'b0;
            force_clear <= 1'b0;
        end else if (hit) begin
            armed <= 1'b0; // Sequence consumed
            force_clear <= 1'b1;
        end else begin
            // Re-arm only on a fresh first byte
            armed <= (data_in == trigger_first);
            force_clear <= 1'b0;
        end
    end

    // Disarming on a hit keeps the clear to one cycle
    clear_single_cycle: assert property (
        @(posedge clk) disable iff (rst)
        force_clear |=> !force_clear
    ) else $error("force_clear high on consecutive cycles");

endmodule

// ==== design/pwm_channel_bank.sv ====
// PWM channel compare bank
`include "pwm_consts.svh"

module pwm_channel_bank
    import pwm_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  duty_t [`PWM_CHANNELS-1:0] duty_cycles,
    input  pattern_byte_t pattern_byte,
    pwm_timebase_if.bank tb,
    output chan_bits_t pwm_outputs
);

    duty_t eff_duty [`PWM_CHANNELS];

    // Channel j flips duty bit j when pattern bit j is set
    always_comb begin
        for (int j = 0; j < `PWM_CHANNELS; j++) begin
            eff_duty[j] = duty_cycles[j] ^ (duty_t'(pattern_byte[j]) << j);
        end
    end

    // Registered compare one cycle behind the count
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pwm_outputs <= '0;
        end else if (tb.clear || !tb.running) begin
            pwm_outputs <= '0;
        end else begin
            for (int j = 0; j < `PWM_CHANNELS; j++) begin
                pwm_outputs[j] <= (tb.count < eff_duty[j]);
            end
        end
    end

endmodule

// ==== design/pwm_host_top.sv ====
// Three-channel PWM host
`include "pwm_consts.svh"

module pwm_host_top
    import pwm_pkg::*;
#(
    parameter pattern_t pattern_seed = `PATTERN_SEED,
    parameter pattern_byte_t trigger_first = `TRIGGER_FIRST,
    parameter pattern_byte_t trigger_second = `TRIGGER_SECOND
) (
    input  logic clk,
    input  logic rst,
    input  duty_t [`PWM_CHANNELS-1:0] duty_cycles, // Channel 0 in the low bits
    input  duty_t period_value,
    input  logic pwm_enable,
    output chan_bits_t pwm_outputs,
    output logic period_complete
);

    pattern_byte_t pattern_byte;
    logic force_clear;

    pwm_timebase_if tb_if ();

    assign tb_if.clear = force_clear;

    pwm_timebase u_timebase (
        .clk             (clk),
        .rst             (rst),
        .enable          (pwm_enable),
        .period_value    (period_value),
        .period_complete (period_complete),
        .tb              (tb_if.timebase)
    );

    // Pattern stream rotates its window once per period
    pattern_source #(
        .seed (pattern_seed)
    ) u_pattern (
        .clk          (clk),
        .rst          (rst),
        .enable       (pwm_enable),
        .period_pulse (tb_if.period_pulse),
        .pattern_byte (pattern_byte)
    );

    trigger_detector #(
        .trigger_first  (trigger_first),
        .trigger_second (trigger_second)
    ) u_trigger (
        .clk         (clk),
        .rst         (rst),
        .data_in     (pattern_byte),
        .force_clear (force_clear)
    );

    pwm_channel_bank u_bank (
        .clk          (clk),
        .rst          (rst),
        .duty_cycles  (duty_cycles),
        .pattern_byte (pattern_byte),
        .tb           (tb_if.bank),
        .pwm_outputs  (pwm_outputs)
    );

endmodule

// ==== test/pwm_host_tb.sv ====
// PWM host testbench
`include "pwm_consts.svh"

module pwm_host_tb
    import pwm_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PERIOD = 20;
    localparam int TRIGGER_CYCLE = 300;             // Enabled cycle of the first trigger byte
    localparam int PULSE_TIMEOUT = 4 * (PERIOD + 2);
    localparam int TRIGGER_TIMEOUT = 600;
    localparam pattern_t TAP_MASK = 26'h2208010;    // Taps 25, 21, 15, 4

    // Model of all registers in the design
    typedef struct packed {
        timebase_state_t state;
        duty_t count;
        logic period_q;
        pattern_t lfsr;
        chan_sel_t chan_sel;
        logic armed;
        logic force_clear;
        chan_bits_t outputs;
    } model_t;

    // Byte offered to the detector at a given enabled cycle if no clear came before
    function automatic pattern_byte_t offered_byte(input int period, input int at_cycle);
        pattern_t lfsr;
        int sel;
        int state;
        int count;
        logic pulse;
        pattern_byte_t window;
        pattern_byte_t found;
        lfsr = `PATTERN_SEED;
        sel = 0;
        state = 0;
        count = 0;
        pulse = 1'b0;
        found = '0;
        for (int c = 0; c <= at_cycle; c++) begin
            case (sel)
                0: window = lfsr[7:0];
                1: window = lfsr[15:8];
                default: window = lfsr[23:16];
            endcase
            if (c == at_cycle)
                found = window;
            if (pulse)
                sel = (sel == 2) ? 0 : sel + 1;  // Rotation follows the period pulse
            lfsr = {lfsr[`LFSR_WIDTH-2:0], ^(lfsr & TAP_MASK)};
            pulse = 1'b0;
            if (state == 0) begin
                state = 1;
                count = 0;
            end else if (state == 1) begin
                if (count < period) begin
                    count = count + 1;
                end else begin
                    count = 0;
                    pulse = 1'b1;
                    state = 2;
                end
            end else begin
                state = 1;
            end
        end
        return found;
    endfunction

    localparam pattern_byte_t TRIG_FIRST = offered_byte(PERIOD, TRIGGER_CYCLE);
    localparam pattern_byte_t TRIG_SECOND = offered_byte(PERIOD, TRIGGER_CYCLE + 1);

    logic clk;
    logic rst;
    logic pwm_enable;
    duty_t period_value;
    duty_t [`PWM_CHANNELS-1:0] duty_cycles;
    chan_bits_t pwm_outputs;
    logic period_complete;

    integer seed = 93228;
    model_t model;
    int clear_count = 0;

    pwm_host_top #(
        .trigger_first  (TRIG_FIRST),
        .trigger_second (TRIG_SECOND)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .duty_cycles     (duty_cycles),
        .period_value    (period_value),
        .pwm_enable      (pwm_enable),
        .pwm_outputs     (pwm_outputs),
        .period_complete (period_complete)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic model_t reset_model();
        model_t m;
        m.state = TB_IDLE;
        m.count = '0;
        m.period_q = 1'b0;
        m.lfsr = `PATTERN_SEED;
        m.chan_sel = '0;
        m.armed = 1'b0;
        m.force_clear = 1'b0;
        m.outputs = '0;
        return m;
    endfunction

    // One clock edge of the whole design
    function automatic model_t step_model(input model_t m, input logic en, input duty_t per,
                                          input duty_t [`PWM_CHANNELS-1:0] duty);
        model_t n;
        pattern_byte_t pb;
        logic running;
        logic hit;
        duty_t eff;
        n = m;
        case (m.chan_sel)
            2'd1: pb = m.lfsr[15:8];
            2'd2: pb = m.lfsr[23:16];
            default: pb = m.lfsr[7:0];
        endcase
        running = en && !m.force_clear;

        if (!running) begin
            n.state = TB_IDLE;
            n.count = '0;
            n.period_q = 1'b0;
        end else begin
            n.period_q = 1'b0;
            if (m.state == TB_IDLE) begin
                n.state = TB_COUNT;
                n.count = '0;
            end else if (m.state == TB_WRAP) begin
                n.state = TB_COUNT;
            end else if (m.count < per) begin
                n.count = m.count + 1'b1;
            end else begin
                n.count = '0;
                n.period_q = 1'b1;
                n.state = TB_WRAP;
            end
        end

        if (en) begin
            n.lfsr = {m.lfsr[`LFSR_WIDTH-2:0], ^(m.lfsr & TAP_MASK)};
            if (m.period_q)
                n.chan_sel = (m.chan_sel == 2'd2) ? 2'd0 : m.chan_sel + 1'b1;
        end

        hit = m.armed && (pb == TRIG_SECOND);
        n.force_clear = hit;
        n.armed = !hit && (pb == TRIG_FIRST);

        for (int j = 0; j < `PWM_CHANNELS; j++) begin
            eff = duty[j];
            if (pb[j])
                eff[j] = !eff[j];  // Perturbed duty bit
            n.outputs[j] = running && (m.count < eff);
        end
        return n;
    endfunction

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_outputs(input chan_bits_t got, input chan_bits_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: pwm_outputs %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_period(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t: period_complete %b, expected %b", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_interval(input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %0t: period interval %0d cycles, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    // Model steps on the edge, DUT is compared mid-cycle
    initial begin : compare_proc
        model = reset_model();
        forever begin
            @(posedge clk);
            if (rst)
                model = reset_model();
            else
                model = step_model(model, pwm_enable, period_value, duty_cycles);
            if (model.force_clear)
                clear_count++;
            @(negedge clk);
            check_outputs(pwm_outputs, model.outputs);
            check_period(period_complete, model.period_q);
        end
    end

    task automatic drive_random_duty();
        duty_t [`PWM_CHANNELS-1:0] d;
        for (int j = 0; j < `PWM_CHANNELS; j++)
            d[j] = duty_t'($unsigned($random(seed)) % (PERIOD + 5));
        @(posedge clk);
        duty_cycles <= d;
    endtask

    task automatic wait_period_pulse();
        int waited;
        waited = 0;
        @(negedge clk);
        while (period_complete !== 1'b1) begin
            if (waited >= PULSE_TIMEOUT) begin
                $display("Timeout: no period_complete pulse within %0d cycles", PULSE_TIMEOUT);
                abort_run();
            end else begin
                waited++;
                @(negedge clk);
            end
        end
    endtask

    // Cycles from one period pulse to the next
    task automatic measure_interval(output int cycles);
        int n;
        logic done;
        wait_period_pulse();
        n = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            n++;
            if (period_complete === 1'b1) begin
                done = 1'b1;
            end else if (n > PULSE_TIMEOUT) begin
                $display("Timeout: second period_complete pulse missing");
                abort_run();
            end
        end
        cycles = n;
    endtask

    initial begin : stimulus
        int interval;
        int waited;
        rst = 1'b1;
        pwm_enable = 1'b0;
        period_value = duty_t'(PERIOD);
        duty_cycles = '0;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            check_outputs(pwm_outputs, '0);
            check_period(period_complete, 1'b0);
        end

        drive_random_duty();
        pwm_enable <= 1'b1;  // Same edge as the first duties
        repeat (3) begin
            measure_interval(interval);
            check_interval(interval, PERIOD + 2);
            drive_random_duty();
        end

        // Keep changing duties until the trigger fires
        waited = 0;
        while (clear_count == 0) begin
            if (waited >= TRIGGER_TIMEOUT) begin
                $display("Timeout: trigger sequence did not clear the design");
                abort_run();
            end else begin
                if (waited % 16 == 0)
                    drive_random_duty();
                @(negedge clk);
                waited++;
            end
        end
        repeat (2) begin
            measure_interval(interval);
            check_interval(interval, PERIOD + 2);
        end

        // Zero duty, always-high and above-period duties
        @(posedge clk);
        duty_cycles <= {duty_t'(PERIOD + 10), 12'hFFF, 12'h000};
        repeat (3) wait_period_pulse();

        @(posedge clk);
        pwm_enable <= 1'b0;
        @(negedge clk);  // Enable not yet sampled
        repeat (6) begin
            @(negedge clk);
            check_outputs(pwm_outputs, '0);
            check_period(period_complete, 1'b0);
        end
        @(posedge clk);
        pwm_enable <= 1'b1;
        drive_random_duty();
        repeat (2) begin
            measure_interval(interval);
            check_interval(interval, PERIOD + 2);
        end

        @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+design
design/pwm_pkg.sv
design/pwm_timebase_if.sv
design/pwm_timebase.sv
design/pattern_source.sv
design/trigger_detector.sv
design/pwm_channel_bank.sv
design/pwm_host_top.sv
test/pwm_host_tb.sv

// ==== Makefile ====
# Verilator build for the PWM host testbench

VERILATOR ?= verilator
TOP       ?= pwm_host_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --timing --assert --timescale 1ns/100ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Verdict comes from the log, not from the simulator exit status
sim: build
	rm -f $(LOG)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
